// File: hw/rom_arbiter.sv
// round robin rom arbiter
`default_nettype none

module rom_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    // slot side
    input  logic [1:0]                 req,
    input  logic [rom_pkg::MEM_AW-1:0] addr0,
    input  logic [rom_pkg::MEM_AW-1:0] addr1,
    output logic [1:0]                 fill,
    output rom_pkg::rom_word_u         fill_data,
    // memory side
    output rom_pkg::mem_req_t          mem_req,
    input  rom_pkg::mem_rsp_t          mem_rsp
);

    import rom_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t            state;
    // slot favoured at the next grant, 0 is the 8-bit slot
    logic              prio;
    // slot being served while busy
    logic              cur;
    logic              gnt;
    logic              start;
    logic              ack_ok;
    logic              rd_q;
    logic [MEM_AW-1:0] addr_q;

    // favoured slot wins if it asks, else the other one
    assign gnt = req[prio] ? prio : ~prio;

    // a new read starts only from idle
    assign start = (state == ST_IDLE) && (|req);

    // ack only counts while a read is outstanding
    assign ack_ok = (state == ST_BUSY) && mem_rsp.ack;

    // one-hot fill back to the owner, same cycle as ack
    assign fill      = {ack_ok && cur, ack_ok && !cur};
    assign fill_data = mem_rsp.data;

    assign mem_req = '{rd: rd_q, addr: addr_q};

    // grant FSM and round robin pointer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            prio  <= 1'b0;
            cur   <= 1'b0;
            rd_q  <= 1'b0;
        end else begin
            // rd is a single-cycle strobe
            rd_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_BUSY;
                        rd_q  <= 1'b1;
                        cur   <= gnt;
                        // other slot goes first next time
                        prio  <= ~gnt;
                    end
                end
                ST_BUSY: begin
                    // one ack closes the read
                    if (mem_rsp.ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address of the granted slot, held for the read
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= gnt ? addr1 : addr0;
        end
    end

endmodule

`default_nettype wire

// File: hw/rom_bus_top.sv
// rom fetch subsystem top
`default_nettype none

module rom_bus_top (
    input  logic                       clk,
    input  logic                       rst,
    // invalidates both caches
    input  logic                       clr,
    // 8-bit requester
    input  logic [rom_pkg::CPU_AW-1:0] cpu_addr,
    input  logic                       cpu_addr_ok,
    output logic                       cpu_data_ok,
    output logic [7:0]                 cpu_dout,
    // 16-bit requester
    input  logic [rom_pkg::CPU_AW-1:0] gfx_addr,
    input  logic                       gfx_addr_ok,
    output logic                       gfx_data_ok,
    output logic [15:0]                gfx_dout,
    // external memory port
    output rom_pkg::mem_req_t          mem_req,
    input  rom_pkg::mem_rsp_t          mem_rsp
);

    import rom_pkg::*;

    // bit 0 is the 8-bit slot, bit 1 the 16-bit slot
    logic [1:0]        req;
    logic [1:0]        fill;
    logic [MEM_AW-1:0] cpu_sdram_addr;
    logic [MEM_AW-1:0] gfx_sdram_addr;
    rom_word_u         fill_data;

    // byte slot at the bottom region
    rom_slot #(
        .DW     (8),
        .OFFSET (CPU_OFFSET)
    ) u_cpu (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .addr       (cpu_addr),
        .addr_ok    (cpu_addr_ok),
        .data_ok    (cpu_data_ok),
        .dout       (cpu_dout),
        .req        (req[0]),
        .sdram_addr (cpu_sdram_addr),
        .fill       (fill[0]),
        .fill_data  (fill_data)
    );

    // halfword slot in the graphics region
    rom_slot #(
        .DW     (16),
        .OFFSET (GFX_OFFSET)
    ) u_gfx (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .addr       (gfx_addr),
        .addr_ok    (gfx_addr_ok),
        .data_ok    (gfx_data_ok),
        .dout       (gfx_dout),
        .req        (req[1]),
        .sdram_addr (gfx_sdram_addr),
        .fill       (fill[1]),
        .fill_data  (fill_data)
    );

    // single memory port shared by both slots
    rom_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr0     (cpu_sdram_addr),
        .addr1     (gfx_sdram_addr),
        .fill      (fill),
        .fill_data (fill_data),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

// File: hw/rom_pkg.sv
// rom fetch shared types
`default_nettype none

package rom_pkg;

    // memory port word address width
    localparam int MEM_AW = 22;

    // requester byte/half address width
    localparam int CPU_AW = 18;

    // region offsets in memory words
    // 8-bit slot sits at the bottom of the rom
    localparam logic [MEM_AW-1:0] CPU_OFFSET = 22'h000000;
    // 16-bit slot region starts 64k words up
    localparam logic [MEM_AW-1:0] GFX_OFFSET = 22'h010000;

    // one rom word, decoded per slot width
    // bytes[0] and halves[0] are the least significant lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } rom_word_u;

    // read strobe towards memory
    // rd is high for one cycle per read
    typedef struct packed {
        logic              rd;
        logic [MEM_AW-1:0] addr;
    } mem_req_t;

    // memory reply
    // ack is a one-cycle strobe, data valid with it
    typedef struct packed {
        logic      ack;
        rom_word_u data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/rom_slot.sv
// cached rom read slot
`default_nettype none

module rom_slot #(
    parameter int DW = 8,
    parameter logic [rom_pkg::MEM_AW-1:0] OFFSET = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clr,
    // requester side
    input  logic [rom_pkg::CPU_AW-1:0] addr,
    input  logic                       addr_ok,
    output logic                       data_ok,
    output logic [DW-1:0]              dout,
    // arbiter side
    output logic                       req,
    output logic [rom_pkg::MEM_AW-1:0] sdram_addr,
    input  logic                       fill,
    input  rom_pkg::rom_word_u         fill_data
);

    import rom_pkg::*;

    // number of address bits below the word index
    localparam int SUB = (DW == 8) ? 2 : 1;
    // word index width
    localparam int IW = CPU_AW - SUB;

    logic [IW-1:0]  word_idx;
    logic [SUB-1:0] sub;

    // two most recent words, entry 0 is the newest
    logic [IW-1:0]  tag0;
    logic [IW-1:0]  tag1;
    rom_word_u      data0;
    rom_word_u      data1;
    logic [1:0]     valid;

    logic           hit0;
    logic           hit1;
    logic           hit;
    logic           strobe;
    rom_word_u      data_mux;
    logic [DW-1:0]  sel_data;

    // word aligned index and lane select
    assign word_idx = addr[CPU_AW-1:SUB];
    assign sub      = addr[SUB-1:0];

    // tag compare on both entries
    assign hit0 = valid[0] && (tag0 == word_idx);
    assign hit1 = valid[1] && (tag1 == word_idx);
    assign hit  = hit0 || hit1;

    // ask for memory only on a miss
    // a fill in progress already carries the word
    assign req = addr_ok && !hit && !fill;

    // region offset added to the word index
    assign sdram_addr = MEM_AW'(word_idx) + OFFSET;

    // answer on hit or fresh fill
    // skip the cycle right after a strobe, the requester has not moved on yet
    assign strobe = addr_ok && !data_ok && (hit || fill);

    // fresh data passes straight through in the fill cycle
    assign data_mux = fill ? fill_data : (hit0 ? data0 : data1);

    // lane pick through the matching view of the word
    generate
        if (DW == 8) begin : g_byte
            // two low address bits pick the byte
            assign sel_data = data_mux.bytes[sub];
        end else begin : g_half
            // address bit 0 picks the half
            assign sel_data = data_mux.halves[sub];
        end
    endgenerate

    // valid bits and response strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid   <= 2'b00;
            data_ok <= 1'b0;
        end else begin
            data_ok <= strobe;
            if (clr) begin
                // drop both entries
                valid <= 2'b00;
            end else if (fill) begin
                // newest in entry 0, old entry 0 ages into entry 1
                valid <= {valid[0], 1'b1};
            end
        end
    end

    // cache contents and output data
    always_ff @(posedge clk) begin
        if (fill) begin
            tag1  <= tag0;
            data1 <= data0;
            tag0  <= word_idx;
            data0 <= fill_data;
        end
        // dout only moves together with data_ok
        if (strobe) begin
            dout <= sel_data;
        end
    end

endmodule

`default_nettype wire

// File: tb.f
hw/rom_pkg.sv
hw/rom_slot.sv
hw/rom_arbiter.sv
hw/rom_bus_top.sv
tb/rom_properties.sv
tb/rom_model.sv
tb/rom_checker.sv
tb/tb_top.sv

// File: tb/rom_checker.sv
// response and read count checker
`default_nettype none

module rom_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [rom_pkg::CPU_AW-1:0] cpu_addr,
    input  logic                       cpu_addr_ok,
    input  logic                       cpu_data_ok,
    input  logic [7:0]                 cpu_dout,
    input  logic [7:0]                 cpu_exp,
    input  logic [rom_pkg::CPU_AW-1:0] gfx_addr,
    input  logic                       gfx_addr_ok,
    input  logic                       gfx_data_ok,
    input  logic [15:0]                gfx_dout,
    input  logic [15:0]                gfx_exp,
    input  logic                       mem_rd,
    input  int                         exp_rd,
    input  logic                       done,
    output int                         data_errs,
    output int                         rd_errs
);

    int   rd_count;
    logic compared;

    // all values taken at the edge, the testbench moves inputs 1 unit later
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            data_errs = 0;
            rd_errs   = 0;
            rd_count  = 0;
            compared  = 1'b0;
        end else begin
            if (mem_rd) begin
                rd_count++;
            end
            if (cpu_data_ok && !cpu_addr_ok) begin
                data_errs++;
                $display("cpu port answered at time %0t with no request pending", $time);
            end else if (cpu_data_ok && cpu_dout !== cpu_exp) begin
                data_errs++;
                $display("** Error @ %0t: cpu addr %h expected %h got %h",
                         $time, cpu_addr, cpu_exp, cpu_dout);
            end
            if (gfx_data_ok && !gfx_addr_ok) begin
                data_errs++;
                $display("gfx port answered at time %0t with no request pending", $time);
            end else if (gfx_data_ok && gfx_dout !== gfx_exp) begin
                data_errs++;
                $display("** Error @ %0t: gfx addr %h expected %h got %h",
                         $time, gfx_addr, gfx_exp, gfx_dout);
            end
            // hits must not reach memory
            if (done && !compared) begin
                compared = 1'b1;
                if (rd_count != exp_rd) begin
                    rd_errs++;
                    $display("** Error @ %0t: mem rd count %0d, predicted misses %0d",
                             $time, rd_count, exp_rd);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/rom_model.sv
// behavioral rom memory
`default_nettype none

module rom_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic              clk,
    input  logic              rst,
    input  rom_pkg::mem_req_t mem_req,
    output rom_pkg::mem_rsp_t mem_rsp
);

    import rom_pkg::*;

    // upper half is the address xor this pattern
    localparam logic [15:0] HI_MASK = 16'hA5C3;

    logic [MEM_AW-1:0] addr_q;
    int                delay;

    // content rule, low half is the low 16 address bits
    function automatic rom_word_u word_at(input logic [MEM_AW-1:0] a);
        rom_word_u w;
        w.halves[0] = a[15:0];
        w.halves[1] = a[15:0] ^ HI_MASK;
        return w;
    endfunction

    initial begin
        mem_rsp = '0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            if (!rst && mem_req.rd) begin
                addr_q = mem_req.addr;
                // latency of 1 to 6 cycles
                delay = 1 + int'($urandom % 6);
                repeat (delay - 1) @(posedge clk);
                #1;
                mem_rsp.data = word_at(addr_q);
                mem_rsp.ack  = 1'b1;
                // ack is a single-cycle strobe
                @(posedge clk);
                #1;
                mem_rsp.ack = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/rom_properties.sv
// arbiter handshake assertions
`default_nettype none

module rom_properties (
    input logic                       clk,
    input logic                       rst,
    input logic [1:0]                 req,
    input logic [rom_pkg::MEM_AW-1:0] addr0,
    input logic [rom_pkg::MEM_AW-1:0] addr1,
    input logic [1:0]                 fill,
    input logic                       busy,
    input rom_pkg::mem_req_t          mem_req,
    input rom_pkg::mem_rsp_t          mem_rsp
);

    import rom_pkg::*;

    int                fails = 0;
    // owner of the latest fill, starts as if the 16-bit slot went last
    logic              last_owner;
    // word address of the read in flight
    logic [MEM_AW-1:0] rd_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_owner <= 1'b1;
        end else if (|fill) begin
            last_owner <= fill[1];
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.rd) begin
            rd_addr <= mem_req.addr;
        end
    end

    // rd leaves only on the idle to busy step
    a_rd_idle: assert property (@(posedge clk) disable iff (rst)
        mem_req.rd |-> busy && $past(!busy))
        else begin fails++; $error("rd issued outside the idle state"); end

    // a single ack per read, never while idle or with rd
    a_ack_once: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.ack |-> busy && !mem_req.rd)
        else begin fails++; $error("ack without an outstanding read"); end

    // the word goes back to the slot whose address was read
    // the owner still holds its address in the fill cycle
    a_fill_onehot: assert property (@(posedge clk) disable iff (rst)
        (|fill) |-> $onehot(fill) && mem_rsp.ack && rd_addr == (fill[1] ? addr1 : addr0))
        else begin fails++; $error("fill not one-hot, without ack or to the wrong slot"); end

    // with both slots waiting the grant goes to the slot not served last
    a_alternate: assert property (@(posedge clk) disable iff (rst)
        (!busy && req == 2'b11) |=>
            mem_req.rd && mem_req.addr == (last_owner ? $past(addr0) : $past(addr1)))
        else begin fails++; $error("grant did not alternate"); end

endmodule

bind rom_arbiter rom_properties u_props (.busy(state), .*);

`default_nettype wire

// File: tb/rom_stimulus.txt
// op cpu_addr cpu_exp gfx_addr gfx_exp, all hex
// op 0 cpu only, 1 gfx only, 2 both ports together, 3 clear both caches
0 01235 04 00000 0000
0 01234 8d 00000 0000
0 01236 4e 00000 0000
0 01237 a1 00000 0000
0 01238 8e 00000 0000
0 01233 a1 00000 0000
0 0123a 4d 00000 0000
0 01235 04 00000 0000
0 3ffff 5a 00000 0000
1 00000 00 0abcd f025
1 00000 00 0abcc 55e6
1 00000 00 0abce 55e7
1 00000 00 0abcf f024
1 00000 00 2abcd f025
1 00000 00 0abcd f025
2 00100 40 00100 0080
2 00205 00 00203 a4c2
2 00100 40 00203 a4c2
3 00000 00 00000 0000
2 00100 40 00203 a4c2

// File: tb/tb_top.sv
// rom fetch testbench
`default_nettype none

module tb_top;

    import rom_pkg::*;

    // cycles allowed per request
    localparam int REQ_LIMIT = 40;
    localparam int MAX_ROWS  = 64;

    logic              clk;
    logic              rst;
    logic              clr;
    logic [CPU_AW-1:0] cpu_addr;
    logic              cpu_addr_ok;
    logic              cpu_data_ok;
    logic [7:0]        cpu_dout;
    logic [CPU_AW-1:0] gfx_addr;
    logic              gfx_addr_ok;
    logic              gfx_data_ok;
    logic [15:0]       gfx_dout;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    // expected value of the pending request per port
    logic [7:0]        cpu_exp;
    logic [15:0]       gfx_exp;
    int                exp_rd;
    logic              done;
    logic              loaded;
    int                data_errs;
    int                rd_errs;
    int                timeouts;
    int                n_rows;
    int                row_op [MAX_ROWS];
    int                row_ca [MAX_ROWS];
    int                row_ce [MAX_ROWS];
    int                row_ga [MAX_ROWS];
    int                row_ge [MAX_ROWS];
    // two-entry cache model per port, entry 0 newest
    logic [16:0]       tag_m [2][2];
    logic              vld_m [2][2];

    rom_bus_top dut (.*);
    rom_model #(.SEED(32'he747)) u_mem (.*);
    rom_checker u_chk (.mem_rd(mem_req.rd), .*);

    always #2 clk = ~clk;

    function automatic int error_total();
        return data_errs + rd_errs + timeouts + dut.u_arb.u_props.fails;
    endfunction

    task automatic print_counts();
        $display("errors: data %0d, rd count %0d, timeout %0d, assertion %0d",
                 data_errs, rd_errs, timeouts, dut.u_arb.u_props.fails);
    endtask

    // a miss costs one mem rd and pushes the word into entry 0
    task automatic predict_fetch(input int p, input logic [16:0] idx);
        if (!((vld_m[p][0] && tag_m[p][0] == idx) || (vld_m[p][1] && tag_m[p][1] == idx))) begin
            exp_rd++;
            tag_m[p][1] = tag_m[p][0];
            vld_m[p][1] = vld_m[p][0];
            tag_m[p][0] = idx;
            vld_m[p][0] = 1'b1;
        end
    endtask

    // one requester handshake, level addr_ok held until data_ok
    task automatic read_port(input int p, input logic [CPU_AW-1:0] a, input logic [15:0] e);
        int   n;
        logic seen;
        if (p == 0) begin
            predict_fetch(0, {1'b0, a[CPU_AW-1:2]});
            cpu_exp     = e[7:0];
            cpu_addr    = a;
            cpu_addr_ok = 1'b1;
        end else begin
            predict_fetch(1, a[CPU_AW-1:1]);
            gfx_exp     = e;
            gfx_addr    = a;
            gfx_addr_ok = 1'b1;
        end
        n    = 0;
        seen = 1'b0;
        while (!seen && n < REQ_LIMIT) begin
            @(posedge clk);
            seen = (p == 0) ? cpu_data_ok : gfx_data_ok;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("port %0d got no data_ok within %0d cycles for address %h", p, REQ_LIMIT, a);
        end
        #1;
        if (p == 0) begin
            cpu_addr_ok = 1'b0;
        end else begin
            gfx_addr_ok = 1'b0;
        end
        // one idle cycle between requests
        @(posedge clk);
        #1;
    endtask

    initial begin
        string line;
        int    fd;
        int    op;
        int    ca;
        int    ce;
        int    ga;
        int    ge;
        clk         = 1'b0;
        rst         = 1'b1;
        clr         = 1'b0;
        cpu_addr    = '0;
        cpu_addr_ok = 1'b0;
        gfx_addr    = '0;
        gfx_addr_ok = 1'b0;
        cpu_exp     = '0;
        gfx_exp     = '0;
        exp_rd      = 0;
        done        = 1'b0;
        loaded      = 1'b0;
        timeouts    = 0;
        n_rows      = 0;
        vld_m       = '{default: '0};
        tag_m       = '{default: '0};
        fd = $fopen("tb/rom_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/rom_stimulus.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            while (!$feof(fd) && n_rows < MAX_ROWS) begin
                // comment lines give no fields and are skipped
                if ($fgets(line, fd) > 0) begin
                    if ($sscanf(line, "%h %h %h %h %h", op, ca, ce, ga, ge) == 5) begin
                        row_op[n_rows] = op;
                        row_ca[n_rows] = ca;
                        row_ce[n_rows] = ce;
                        row_ga[n_rows] = ga;
                        row_ge[n_rows] = ge;
                        n_rows++;
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            #1 rst = 1'b0;
            @(posedge clk);
            #1;
            for (int i = 0; i < n_rows; i++) begin
                case (row_op[i])
                    0: read_port(0, row_ca[i], row_ce[i]);
                    1: read_port(1, row_ga[i], row_ge[i]);
                    // both ports miss together, arbiter must serve both
                    2: fork
                        read_port(0, row_ca[i], row_ce[i]);
                        read_port(1, row_ga[i], row_ge[i]);
                    join
                    default: begin
                        clr   = 1'b1;
                        vld_m = '{default: '0};
                        @(posedge clk);
                        #1 clr = 1'b0;
                    end
                endcase
            end
            // checker compares the rd count at the next edge
            done = 1'b1;
            @(posedge clk);
            #1;
            print_counts();
            if (error_total() == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    // watchdog scaled by the number of stimulus rows
    initial begin
        wait (loaded);
        #((n_rows + 4) * REQ_LIMIT * 4);
        $display("watchdog expired before the stimulus finished");
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
